// File: design/mole_pkg.sv
package mole_pkg;

    localparam int MOLE_COUNT  = 9;
    localparam int LFSR_WIDTH  = 16;
    localparam int SEC_PERIOD  = 100_000_000;  // 1 s at 100 MHz
    localparam int SCAN_PERIOD = 16_384;       // per display slot

    typedef logic [4:0] count_t;
    typedef logic [3:0] digit_code_t;

    localparam count_t ROUND_SECONDS = 5'd30;
    localparam count_t WIN_SCORE     = 5'd10;

    typedef enum logic [1:0] {
        st_initial,
        st_game,
        st_final
    } game_state_t;

    // symbol codes above the decimal digits
    localparam digit_code_t CODE_W     = 4'd10;
    localparam digit_code_t CODE_I     = 4'd11;
    localparam digit_code_t CODE_N     = 4'd12;
    localparam digit_code_t CODE_DASH  = 4'd13;
    localparam digit_code_t CODE_BLANK = 4'd15;

    // index 0 seeds mole 1
    localparam logic [LFSR_WIDTH-1:0] MOLE_SEEDS [MOLE_COUNT] = '{
        16'h8400,
        16'h0800,
        16'h2002,
        16'h0080,
        16'h0100,
        16'h0020,
        16'h0001,
        16'h0004,
        16'h1000
    };

    // gfedcba, active low
    localparam logic [6:0] SEG_PATTERNS [16] = '{
        7'b100_0000,  // 0
        7'b111_1001,  // 1
        7'b010_0100,  // 2
        7'b011_0000,  // 3
        7'b001_1001,  // 4
        7'b001_0010,  // 5
        7'b000_0010,  // 6
        7'b111_1000,  // 7
        7'b000_0000,  // 8
        7'b001_0000,  // 9
        7'b110_0010,  // W
        7'b100_1111,  // I
        7'b100_1000,  // N
        7'b011_1111,  // dash
        7'b111_1111,
        7'b111_1111
    };

    typedef struct packed {
        logic       valid;
        logic [3:0] num;
    } key_event_t;

    typedef struct packed {
        game_state_t state;
        count_t      countdown;
        count_t      score;
    } game_status_t;

endpackage

// File: design/tick_gen.sv
`timescale 1ns/10ps

module tick_gen #(
    parameter int PERIOD = 2
) (
    input  logic clk,
    input  logic rst,
    output logic tick
);

    localparam int CNT_W = $clog2(PERIOD);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (cnt == CNT_W'(PERIOD - 1)) begin
            cnt <= '0;  // wrap
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // high for the last cycle of each period
    assign tick = (cnt == CNT_W'(PERIOD - 1));

endmodule

// File: design/game_ctrl.sv
`timescale 1ns/10ps

module game_ctrl import mole_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         start,
    input  logic         sec_tick,
    input  logic         hit,
    output game_status_t status,
    output logic         playing
);

    game_state_t state;
    count_t      countdown;
    count_t      score;
    logic        start_q;
    logic        start_rise;
    logic        round_over;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start_q <= 1'b0;
        end else begin
            start_q <= start;
        end
    end

    assign start_rise = start & ~start_q;

    // timeout or enough points
    assign round_over = (countdown == '0) || (score >= WIN_SCORE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= st_initial;
            countdown <= ROUND_SECONDS;
            score     <= '0;
        end else begin
            case (state)
                st_game: begin
                    if (round_over) begin
                        state <= st_final;  // freeze count and score
                    end else begin
                        if (sec_tick) begin
                            countdown <= countdown - 5'd1;
                        end
                        if (hit) begin
                            score <= score + 5'd1;
                        end
                    end
                end
                st_initial, st_final: begin
                    if (start_rise) begin
                        state     <= st_game;
                        countdown <= ROUND_SECONDS;
                        score     <= '0;
                    end
                end
                default: begin
                    state <= st_initial;
                end
            endcase
        end
    end

    assign playing = (state == st_game);

    assign status.state     = state;
    assign status.countdown = countdown;
    assign status.score     = score;

endmodule

// File: design/mole_field.sv
`timescale 1ns/10ps

module mole_field import mole_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        sec_tick,
    input  logic        playing,
    input  key_event_t  key,
    output logic        hit,
    output logic [15:0] led
);

    logic [LFSR_WIDTH-1:0] lfsr [MOLE_COUNT];
    logic [MOLE_COUNT-1:0] hit_mask;
    logic [MOLE_COUNT-1:0] lit;
    logic [MOLE_COUNT-1:0] strike;
    logic [15:0]           led_next;

    // free running, steps once per second in every state
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < MOLE_COUNT; i++) begin
                lfsr[i] <= MOLE_SEEDS[i];
            end
        end else if (sec_tick) begin
            for (int i = 0; i < MOLE_COUNT; i++) begin
                lfsr[i] <= {lfsr[i][5] ^ lfsr[i][3] ^ lfsr[i][2] ^ lfsr[i][0],
                            lfsr[i][LFSR_WIDTH-1:1]};
            end
        end
    end

    always_comb begin
        for (int i = 0; i < MOLE_COUNT; i++) begin
            lit[i]    = lfsr[i][LFSR_WIDTH-1] & ~hit_mask[i];
            // key k strikes mole k, index k-1
            strike[i] = playing & key.valid & lit[i] & (key.num == 4'(i + 1));
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hit_mask <= '0;
            hit      <= 1'b0;
        end else begin
            hit <= |strike;
            if (!playing || sec_tick) begin
                hit_mask <= '0;
            end else begin
                hit_mask <= hit_mask | strike;
            end
        end
    end

    // mole k lights led[16-k], low seven stay dark
    always_comb begin
        led_next = '0;
        for (int i = 0; i < MOLE_COUNT; i++) begin
            led_next[15-i] = lit[i];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            led <= '0;
        end else if (playing) begin
            led <= led_next;
        end else begin
            led <= '0;
        end
    end

endmodule

// File: design/score_digits.sv
`timescale 1ns/10ps

module score_digits import mole_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  game_status_t      status,
    output digit_code_t [3:0] digits
);

    function automatic digit_code_t tens_of(count_t value);
        return digit_code_t'(value / 10);
    endfunction

    function automatic digit_code_t units_of(count_t value);
        return digit_code_t'(value % 10);
    endfunction

    // digit 3 is the leftmost
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            digits <= {4{CODE_DASH}};
        end else begin
            case (status.state)
                st_game: begin
                    digits[3] <= tens_of(status.countdown);
                    digits[2] <= units_of(status.countdown);
                    digits[1] <= tens_of(status.score);
                    digits[0] <= units_of(status.score);
                end
                st_final: begin
                    if (status.score >= WIN_SCORE) begin
                        digits[3] <= CODE_DASH;  // "-WIN"
                        digits[2] <= CODE_W;
                        digits[1] <= CODE_I;
                        digits[0] <= CODE_N;
                    end else begin
                        digits[3] <= 4'd0;
                        digits[2] <= 4'd0;
                        digits[1] <= tens_of(status.score);
                        digits[0] <= units_of(status.score);
                    end
                end
                default: begin
                    digits <= {4{CODE_DASH}};
                end
            endcase
        end
    end

endmodule

// File: design/seg_scan.sv
`timescale 1ns/10ps

module seg_scan import mole_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              scan_tick,
    input  digit_code_t [3:0] digits,
    output logic [3:0]        digit_sel,
    output logic [6:0]        segments
);

    digit_code_t code;

    // one low bit walks 0 -> 1 -> 2 -> 3
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            digit_sel <= 4'b1111;  // dark until first slot
        end else if (scan_tick) begin
            if (&digit_sel) begin
                digit_sel <= 4'b1110;
            end else begin
                digit_sel <= {digit_sel[2:0], digit_sel[3]};
            end
        end
    end

    always_comb begin
        case (digit_sel)
            4'b1110: begin
                code = digits[0];
            end
            4'b1101: begin
                code = digits[1];
            end
            4'b1011: begin
                code = digits[2];
            end
            4'b0111: begin
                code = digits[3];
            end
            default: begin
                code = CODE_BLANK;
            end
        endcase
    end

    assign segments = SEG_PATTERNS[code];

endmodule

// File: design/whack_top.sv
`timescale 1ns/10ps

module whack_top import mole_pkg::*; #(
    parameter int SEC_TICKS  = SEC_PERIOD,
    parameter int SCAN_TICKS = SCAN_PERIOD
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  key_event_t  key,
    output logic [15:0] led,
    output logic [3:0]  digit_sel,
    output logic [6:0]  segments
);

    logic              sec_tick;
    logic              scan_tick;
    logic              playing;
    logic              hit;
    game_status_t      status;
    digit_code_t [3:0] digits;

    tick_gen #(.PERIOD(SEC_TICKS)) i_sec_tick (
        .clk  (clk),
        .rst  (rst),
        .tick (sec_tick)
    );

    tick_gen #(.PERIOD(SCAN_TICKS)) i_scan_tick (
        .clk  (clk),
        .rst  (rst),
        .tick (scan_tick)
    );

    game_ctrl i_game_ctrl (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .sec_tick (sec_tick),
        .hit      (hit),
        .status   (status),
        .playing  (playing)
    );

    mole_field i_mole_field (
        .clk      (clk),
        .rst      (rst),
        .sec_tick (sec_tick),
        .playing  (playing),
        .key      (key),
        .hit      (hit),
        .led      (led)
    );

    score_digits i_score_digits (
        .clk    (clk),
        .rst    (rst),
        .status (status),
        .digits (digits)
    );

    seg_scan i_seg_scan (
        .clk       (clk),
        .rst       (rst),
        .scan_tick (scan_tick),
        .digits    (digits),
        .digit_sel (digit_sel),
        .segments  (segments)
    );

endmodule

// File: verification/whack_tb.sv
`timescale 1ns/10ps

module whack_tb import mole_pkg::*; ();

    localparam int SEC_TICKS  = 200;
    localparam int SCAN_TICKS = 4;

    logic        clk;
    logic        rst;
    logic        start;
    key_event_t  key;
    logic [15:0] led;
    logic [3:0]  digit_sel;
    logic [6:0]  segments;

    // reference model
    int                    sec_cnt;
    int                    scan_cnt;
    logic                  sec_now;
    logic                  scan_now;
    logic                  m_tick_q;    // high the cycle after a second tick
    game_state_t           m_state;
    count_t                m_cd;
    count_t                m_score;
    logic                  m_start_q;
    logic                  m_hit;
    logic [MOLE_COUNT-1:0] m_mask;
    logic [MOLE_COUNT-1:0] m_lit;
    logic [MOLE_COUNT-1:0] m_strike;
    logic [LFSR_WIDTH-1:0] m_lfsr [MOLE_COUNT];
    logic [15:0]           m_led_next;
    logic [15:0]           m_led;
    logic [3:0]            m_sel;
    digit_code_t [3:0]     m_dig;

    logic [6:0]  cap_seg [4];  // last pattern seen per slot
    logic [3:0]  cap_seen;
    logic [31:0] prng;

    whack_top #(.SEC_TICKS(SEC_TICKS), .SCAN_TICKS(SCAN_TICKS)) i_whack_top (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .key       (key),
        .led       (led),
        .digit_sel (digit_sel),
        .segments  (segments)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        stop_with_failure($sformatf("[ERROR] %0t %s expected %0h actual %0h",
                                    $time, name, expected, actual));
    endtask

    // taps of x^32 + x^22 + x^2 + x + 1
    function automatic int random_bits(input int n);
        int   v;
        logic fb;
        v = 0;
        for (int i = 0; i < n; i++) begin
            fb   = prng[31] ^ prng[21] ^ prng[1] ^ prng[0];
            prng = {prng[30:0], fb};
            v    = (v << 1) | int'(fb);
        end
        return v;
    endfunction

    // key number of the r-th set mole
    function automatic logic [3:0] pick_mole(input logic [MOLE_COUNT-1:0] set, input int r);
        int idx;
        idx = r % $countones(set);
        for (int i = 0; i < MOLE_COUNT; i++) begin
            if (set[i]) begin
                if (idx == 0) begin
                    return 4'(i + 1);
                end
                idx--;
            end
        end
        return 4'd0;
    endfunction

    function automatic digit_code_t shown_code(input game_state_t s, input count_t cd,
                                               input count_t sc, input int slot);
        count_t            v;
        digit_code_t [3:0] win;
        win = {CODE_DASH, CODE_W, CODE_I, CODE_N};
        v   = (slot >= 2) ? cd : sc;
        case (s)
            st_game: begin
                return (slot % 2 == 1) ? digit_code_t'(v / 10) : digit_code_t'(v % 10);
            end
            st_final: begin
                if (sc >= WIN_SCORE) begin
                    return win[slot];
                end
                if (slot >= 2) begin
                    return 4'd0;
                end
                return (slot == 1) ? digit_code_t'(sc / 10) : digit_code_t'(sc % 10);
            end
            default: begin
                return CODE_DASH;
            end
        endcase
    endfunction

    always_comb begin
        sec_now    = (sec_cnt == SEC_TICKS - 1);
        scan_now   = (scan_cnt == SCAN_TICKS - 1);
        m_led_next = '0;
        for (int i = 0; i < MOLE_COUNT; i++) begin
            m_lit[i]    = m_lfsr[i][LFSR_WIDTH-1] & ~m_mask[i];
            m_strike[i] = (m_state == st_game) && key.valid && (key.num == i + 1) && m_lit[i];
            m_led_next[16-(i+1)] = m_lit[i] && (m_state == st_game);  // mole k on led[16-k]
        end
    end

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            sec_cnt   <= 0;
            scan_cnt  <= 0;
            m_tick_q  <= 1'b0;
            m_state   <= st_initial;
            m_cd      <= ROUND_SECONDS;
            m_score   <= '0;
            m_start_q <= 1'b0;
            m_hit     <= 1'b0;
            m_mask    <= '0;
            m_led     <= '0;
            m_sel     <= 4'b1111;
            m_dig     <= {4{CODE_DASH}};
            for (int i = 0; i < MOLE_COUNT; i++) begin
                m_lfsr[i] <= MOLE_SEEDS[i];
            end
        end else begin
            sec_cnt   <= sec_now ? 0 : sec_cnt + 1;
            scan_cnt  <= scan_now ? 0 : scan_cnt + 1;
            m_tick_q  <= sec_now;
            m_start_q <= start;
            m_hit     <= |m_strike;
            m_led     <= m_led_next;
            m_mask    <= (m_state != st_game || sec_now) ? '0 : (m_mask | m_strike);
            if (scan_now) begin
                m_sel <= (m_sel == 4'b1111) ? 4'b1110 : {m_sel[2:0], m_sel[3]};
            end
            for (int i = 0; i < MOLE_COUNT; i++) begin
                if (sec_now) begin
                    m_lfsr[i] <= {m_lfsr[i][5] ^ m_lfsr[i][3] ^ m_lfsr[i][2] ^ m_lfsr[i][0],
                                  m_lfsr[i][LFSR_WIDTH-1:1]};
                end
            end
            for (int k = 0; k < 4; k++) begin
                m_dig[k] <= shown_code(m_state, m_cd, m_score, k);
            end
            if (m_state == st_game) begin
                if (m_cd == 0 || m_score >= WIN_SCORE) begin
                    m_state <= st_final;
                end else begin
                    m_cd    <= sec_now ? m_cd - 5'd1 : m_cd;
                    m_score <= m_hit ? m_score + 5'd1 : m_score;
                end
            end else if (start && !m_start_q) begin
                m_state <= st_game;
                m_cd    <= ROUND_SECONDS;
                m_score <= '0;
            end
        end
    end

    // outputs settle long before the falling edge
    always @(negedge clk) begin
        if (rst === 1'b0) begin
            assert (led[6:0] == 7'd0) else report_mismatch("led[6:0]", 0, led[6:0]);
            assert (led == m_led) else report_mismatch("led", m_led, led);
            if (m_sel != 4'b1111) begin
                assert ($countones(digit_sel) == 3)
                    else stop_with_failure("digit_sel does not have exactly one low bit");
            end
            assert (digit_sel == m_sel) else report_mismatch("digit_sel", m_sel, digit_sel);
            for (int k = 0; k < 4; k++) begin
                if (!m_sel[k]) begin
                    assert (segments == SEG_PATTERNS[m_dig[k]])
                        else report_mismatch($sformatf("segments slot %0d", k),
                                             SEG_PATTERNS[m_dig[k]], segments);
                    cap_seg[k]  = segments;
                    cap_seen[k] = 1'b1;
                end
            end
        end
    end

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #10;
        end
    endtask

    task automatic pulse_start();
        start = 1'b1;
        idle_cycles(1);
        start = 1'b0;
    endtask

    task automatic wait_sec_tick();
        int n;
        n = 0;
        do begin
            idle_cycles(1);
            n++;
            if (n > SEC_TICKS + 4) begin
                stop_with_failure("timeout: no second tick seen");
            end
        end while (!m_tick_q);
    endtask

    task automatic wait_state(input game_state_t want, input int limit);
        int n;
        n = 0;
        while (m_state != want) begin
            idle_cycles(1);
            n++;
            if (n > limit) begin
                stop_with_failure($sformatf("timeout: state %s never reached", want.name()));
            end
        end
    endtask

    task automatic expect_display(input digit_code_t [3:0] want);
        int n;
        n        = 0;
        cap_seen = '0;
        while (cap_seen != 4'hf) begin
            idle_cycles(1);
            n++;
            if (n > 16 * SCAN_TICKS) begin
                stop_with_failure("timeout: display scan did not cover all four digits");
            end
        end
        for (int k = 0; k < 4; k++) begin
            assert (cap_seg[k] == SEG_PATTERNS[want[k]])
                else report_mismatch($sformatf("display digit %0d", k),
                                     SEG_PATTERNS[want[k]], cap_seg[k]);
        end
    endtask

    // keys aimed mostly at lit moles until the round ends
    task automatic play_keys();
        int         n;
        int         choice;
        logic [3:0] num;
        n = 0;
        while (m_state == st_game) begin
            choice = random_bits(2);
            if (choice == 0) begin
                num = 4'(random_bits(4));  // any number including key 0
            end else if (choice < 3 && m_lit != '0) begin
                num = pick_mole(m_lit, random_bits(4));
            end else if (m_mask != '0) begin
                num = pick_mole(m_mask, random_bits(4));  // already hit
            end else begin
                num = 4'd0;
            end
            key.valid = 1'b1;
            key.num   = num;
            idle_cycles(1);
            key = '0;
            idle_cycles(random_bits(3));
            n++;
            if (n > 40 * SEC_TICKS) begin
                stop_with_failure("timeout: round with keys never ended");
            end
        end
    endtask

    initial begin
        rst      = 1'b1;
        start    = 1'b0;
        key      = '0;
        cap_seen = '0;
        prng     = 32'h90fb5391;
        repeat (8) @(posedge clk);
        #10;
        rst = 1'b0;

        expect_display({4{CODE_DASH}});
        assert (led == 16'd0) else report_mismatch("led", 0, led);

        // round with no keys and an ignored second start
        wait_sec_tick();
        pulse_start();
        wait_state(st_game, 4);
        idle_cycles(4);
        expect_display({4'd3, 4'd0, 4'd0, 4'd0});
        wait_sec_tick();
        pulse_start();
        idle_cycles(4);
        expect_display({4'd2, 4'd9, 4'd0, 4'd0});
        wait_state(st_final, (int'(ROUND_SECONDS) + 2) * SEC_TICKS);
        idle_cycles(4);
        expect_display({4'd0, 4'd0, 4'd0, 4'd0});

        // restart from st_final and play to a win
        wait_sec_tick();
        pulse_start();
        wait_state(st_game, 4);
        idle_cycles(4);
        expect_display({4'd3, 4'd0, 4'd0, 4'd0});
        play_keys();
        assert (m_score >= WIN_SCORE)
            else stop_with_failure("round ran out of time before ten hits");
        idle_cycles(4);
        expect_display({CODE_DASH, CODE_W, CODE_I, CODE_N});

        // restart after a win clears the score
        wait_sec_tick();
        pulse_start();
        wait_state(st_game, 4);
        idle_cycles(4);
        expect_display({4'd3, 4'd0, 4'd0, 4'd0});
        idle_cycles(8);

        $display(">>> PASS");
        $finish;
    end

endmodule

// File: compile.f
design/mole_pkg.sv
design/tick_gen.sv
design/game_ctrl.sv
design/mole_field.sv
design/score_digits.sv
design/seg_scan.sv
design/whack_top.sv
verification/whack_tb.sv
